// File: include/vec_macros.svh
// Vector unit sizing constants
// Register count, register width and its byte count
// Default number of element lanes per cycle
`ifndef VEC_MACROS_SVH
`define VEC_MACROS_SVH

// ========================================
// Register file geometry
// ========================================
// Architectural vector registers v0..v31
`define VEC_NUM_REGS 32
// Bits per vector register
`define VEC_VLEN 128
// Bytes per vector register, also the write port width
`define VEC_VBYTES (`VEC_VLEN / 8)

// Elements handled each write cycle; 1, 2 or 4 only
`define VEC_LANES 2

`endif

// File: rtl/vec_pkg.sv
// Vector unit shared types
// SEW and operation encodings, element, offset and register number types
package vec_pkg;

  // Element width code
  typedef enum logic [1:0] {
    SEW8  = 2'b00,
    SEW16 = 2'b01,
    SEW32 = 2'b10
  } sew_t;

  // Element-wise operation
  typedef enum logic [1:0] {
    VOP_ADD = 2'b00,
    VOP_SUB = 2'b01,
    // Copy of vs2
    VOP_MV  = 2'b10
  } vop_t;

  // Element index, vl up to 128
  typedef logic [6:0] offset_t;

  // Zero-extended element word
  typedef logic [31:0] elem_t;

  // Register number
  typedef logic [4:0] regidx_t;

endpackage

// File: rtl/vec_elem_addr.sv
// Element address decoder
// Splits an element index into a register within the group and a byte offset
`timescale 1ns/1ps

module vec_elem_addr import vec_pkg::*; (
  input  regidx_t    base_reg,
  input  sew_t       sew,
  input  offset_t    elem_idx,
  output regidx_t    reg_idx,
  output logic [3:0] byte_off
);

  // Register step above the group base
  regidx_t reg_step;

  // ========================================
  // Index split by element width
  // ========================================
  always_comb begin
    case (sew)
      SEW32: begin
        // 4 elements per register
        reg_step = elem_idx[6:2];
        byte_off = {elem_idx[1:0], 2'b00};
      end
      SEW16: begin
        // 8 elements per register
        reg_step = {1'b0, elem_idx[6:3]};
        byte_off = {elem_idx[2:0], 1'b0};
      end
      default: begin
        // 16 byte elements per register
        reg_step = {2'b00, elem_idx[6:4]};
        byte_off = elem_idx[3:0];
      end
    endcase
  end

  // Group member, wraps past v31
  assign reg_idx = base_reg + reg_step;

endmodule

// File: rtl/vec_reg_file.sv
// Vector register file, 32 x 128 bits
// Lane read ports with SEW extraction, v0 mask bit reads
// Byte-enabled vector write port and a 32-bit host word port
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_reg_file import vec_pkg::*; #(
  parameter int LANES = `VEC_LANES
) (
  input  logic                         CLK,
  input  logic                         nRST,
  // Lane read ports
  input  regidx_t                      rd_reg_a [LANES],
  input  logic [3:0]                   rd_off_a [LANES],
  input  regidx_t                      rd_reg_b [LANES],
  input  logic [3:0]                   rd_off_b [LANES],
  input  sew_t                         sew,
  output elem_t                        rd_data_a [LANES],
  output elem_t                        rd_data_b [LANES],
  // Mask bits from v0
  input  offset_t                      mask_idx [LANES],
  output logic                         mask_bit [LANES],
  // Vector write port
  input  logic                         wr_en,
  input  regidx_t                      wr_reg,
  input  logic [`VEC_VBYTES-1:0][7:0]  w_data,
  input  logic [`VEC_VBYTES-1:0]       byte_ena,
  // Host word port
  input  logic                         host_wen,
  input  regidx_t                      host_wreg,
  input  logic [1:0]                   host_wword,
  input  logic [31:0]                  host_wdata,
  input  regidx_t                      host_rreg,
  input  logic [1:0]                   host_rword,
  output logic [31:0]                  host_rdata
);

  typedef logic [`VEC_VBYTES-1:0][7:0] vreg_t;

  vreg_t regs [`VEC_NUM_REGS];

  // Pull one element out of a register row, zero-extended
  function automatic elem_t read_elem(input vreg_t row, input logic [3:0] off,
                                      input sew_t s);
    elem_t word;
    // Offsets are element aligned, so the 4-bit adds never wrap for a real element
    word = {row[off + 4'd3], row[off + 4'd2], row[off + 4'd1], row[off]};
    case (s)
      SEW8:    return {24'h0, word[7:0]};
      SEW16:   return {16'h0, word[15:0]};
      default: return word;
    endcase
  endfunction

  // ========================================
  // Read ports
  // ========================================
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      rd_data_a[i] = read_elem(regs[rd_reg_a[i]], rd_off_a[i], sew);
      rd_data_b[i] = read_elem(regs[rd_reg_b[i]], rd_off_b[i], sew);
      // One mask bit per element, v0 taken as a flat bit vector
      mask_bit[i]  = regs[0][mask_idx[i][6:3]][mask_idx[i][2:0]];
    end
  end

  // Host read, combinational
  assign host_rdata = regs[host_rreg][{host_rword, 2'b00} +: 4];

  // ========================================
  // Write ports
  // ========================================
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int r = 0; r < `VEC_NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      // Vector write, bytes not enabled hold
      if (wr_en) begin
        for (int j = 0; j < `VEC_VBYTES; j++) begin
          if (byte_ena[j]) begin
            regs[wr_reg][j] <= w_data[j];
          end
        end
      end
      // Host word write
      if (host_wen) begin
        regs[host_wreg][{host_wword, 2'b00} +: 4] <= host_wdata;
      end
    end
  end

endmodule

// File: rtl/vec_lane_alu.sv
// Per-lane vector ALU
// Add, subtract and move, results wrapped to the element width
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_lane_alu import vec_pkg::*; #(
  parameter int LANES = `VEC_LANES
) (
  input  vop_t  op,
  input  sew_t  sew,
  // a from vs1, b from vs2
  input  elem_t a [LANES],
  input  elem_t b [LANES],
  output elem_t result [LANES]
);

  // Full 32-bit results before wrapping
  elem_t raw [LANES];
  // Keeps the low SEW bits
  elem_t width_mask;

  always_comb begin
    case (sew)
      SEW8:    width_mask = 32'h0000_00ff;
      SEW16:   width_mask = 32'h0000_ffff;
      default: width_mask = 32'hffff_ffff;
    endcase
  end

  // ========================================
  // Lane arithmetic
  // ========================================
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      case (op)
        VOP_ADD: raw[i] = b[i] + a[i];
        // vs2 minus vs1
        VOP_SUB: raw[i] = b[i] - a[i];
        default: raw[i] = b[i];
      endcase
      // Wrap modulo 2^SEW
      result[i] = raw[i] & width_mask;
    end
  end

endmodule

// File: rtl/vec_wb_align.sv
// Write-back alignment
// Packs lane results into one register-wide write word with byte enables
// Applies lane validity and v0 mask gating
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_wb_align import vec_pkg::*; #(
  parameter int LANES = `VEC_LANES
) (
  input  sew_t                         sew,
  input  logic                         vm,
  input  elem_t                        result [LANES],
  input  logic [3:0]                   byte_off [LANES],
  input  logic                         lane_valid [LANES],
  input  logic                         mask_bit [LANES],
  output logic [`VEC_VBYTES-1:0][7:0]  w_data,
  output logic [`VEC_VBYTES-1:0]       byte_ena
);

  // Bytes per element
  logic [2:0]       nbytes;
  // Lanes that actually write
  logic [LANES-1:0] lane_en;

  always_comb begin
    case (sew)
      SEW8:    nbytes = 3'd1;
      SEW16:   nbytes = 3'd2;
      default: nbytes = 3'd4;
    endcase
  end

  // vm = 1 means unmasked
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_en[i] = lane_valid[i] & (vm | mask_bit[i]);
    end
  end

  // ========================================
  // Byte placement
  // ========================================
  always_comb begin
    w_data   = '0;
    byte_ena = '0;
    for (int i = 0; i < LANES; i++) begin
      for (int k = 0; k < 4; k++) begin
        if (lane_en[i] && (k < nbytes)) begin
          w_data[byte_off[i] + 4'(k)]   = result[i][8*k +: 8];
          byte_ena[byte_off[i] + 4'(k)] = 1'b1;
        end
      end
    end
  end

endmodule

// File: rtl/vec_seq_ctrl.sv
// Vector operation sequencer
// Idle/run FSM, latched operation fields, lane element indices
// Write enable per cycle and a done strobe after the last write
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_seq_ctrl import vec_pkg::*; #(
  parameter int LANES = `VEC_LANES
) (
  input  logic    CLK,
  input  logic    nRST,
  // Operation request
  input  logic    start,
  input  vop_t    op,
  input  sew_t    sew,
  input  offset_t vl,
  input  regidx_t vd,
  input  regidx_t vs1,
  input  regidx_t vs2,
  input  logic    vm,
  // Status
  output logic    busy,
  output logic    done,
  // Per-cycle datapath control
  output logic    wr_en,
  output offset_t elem_idx [LANES],
  output logic    lane_valid [LANES],
  output vop_t    cur_op,
  output sew_t    cur_sew,
  output regidx_t cur_vd,
  output regidx_t cur_vs1,
  output regidx_t cur_vs2,
  output logic    cur_vm
);

  typedef enum logic {
    ST_IDLE,
    ST_RUN
  } state_t;

  state_t     state;
  // First element of the current cycle
  offset_t    base;
  offset_t    vl_q;
  // One bit wider so base + LANES cannot overflow
  logic [7:0] next_base;
  logic       accept;

  assign accept    = start && (state == ST_IDLE);
  assign next_base = {1'b0, base} + 8'(LANES);

  // ========================================
  // FSM and element counter
  // ========================================
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= ST_IDLE;
      base  <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            base <= '0;
            // vl = 0 has no write cycles
            if (vl == '0) done <= 1'b1;
            else          state <= ST_RUN;
          end
        end
        default: begin
          base <= next_base[6:0];
          // Last group of elements written this cycle
          if (next_base >= {1'b0, vl_q}) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
      endcase
    end
  end

  // Operation fields, held for the whole run
  always_ff @(posedge CLK) begin
    if (accept) begin
      cur_op  <= op;
      cur_sew <= sew;
      vl_q    <= vl;
      cur_vd  <= vd;
      cur_vs1 <= vs1;
      cur_vs2 <= vs2;
      cur_vm  <= vm;
    end
  end

  assign busy  = (state == ST_RUN);
  // Every run cycle writes
  assign wr_en = busy;

  // Lane indices, tail lanes past vl dropped
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      elem_idx[i]   = base + offset_t'(i);
      lane_valid[i] = busy && (({1'b0, base} + 8'(i)) < {1'b0, vl_q});
    end
  end

endmodule

// File: rtl/vec_unit_top.sv
// Vector unit top level
// Sequencer, per-lane address decoders, register file, ALU and write-back align
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_unit_top import vec_pkg::*; #(
  parameter int LANES = `VEC_LANES
) (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        start,
  input  vop_t        op,
  input  sew_t        sew,
  input  offset_t     vl,
  input  regidx_t     vd,
  input  regidx_t     vs1,
  input  regidx_t     vs2,
  input  logic        vm,
  output logic        busy,
  output logic        done,
  input  logic        host_wen,
  input  regidx_t     host_wreg,
  input  logic [1:0]  host_wword,
  input  logic [31:0] host_wdata,
  input  regidx_t     host_rreg,
  input  logic [1:0]  host_rword,
  output logic [31:0] host_rdata
);

  logic    wr_en, cur_vm;
  vop_t    cur_op;
  sew_t    cur_sew;
  regidx_t cur_vd, cur_vs1, cur_vs2;
  offset_t elem_idx [LANES];
  logic    lane_valid [LANES];
  // Decoded operand locations
  regidx_t vs1_reg [LANES], vs2_reg [LANES], vd_reg [LANES];
  logic [3:0] vs1_off [LANES], vs2_off [LANES], vd_off [LANES];
  // Datapath
  elem_t   data_a [LANES], data_b [LANES], result [LANES];
  logic    mask_bit [LANES];
  logic [`VEC_VBYTES-1:0][7:0] w_data;
  logic [`VEC_VBYTES-1:0]      byte_ena;

  vec_seq_ctrl #(.LANES(LANES)) u_ctrl (
    .CLK, .nRST, .start, .op, .sew, .vl, .vd, .vs1, .vs2, .vm,
    .busy, .done, .wr_en, .elem_idx, .lane_valid,
    .cur_op, .cur_sew, .cur_vd, .cur_vs1, .cur_vs2, .cur_vm
  );

  // ========================================
  // Address decode, one set per lane
  // ========================================
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    vec_elem_addr u_vs1_addr (.base_reg(cur_vs1), .sew(cur_sew), .elem_idx(elem_idx[i]),
                              .reg_idx(vs1_reg[i]), .byte_off(vs1_off[i]));
    vec_elem_addr u_vs2_addr (.base_reg(cur_vs2), .sew(cur_sew), .elem_idx(elem_idx[i]),
                              .reg_idx(vs2_reg[i]), .byte_off(vs2_off[i]));
    vec_elem_addr u_vd_addr  (.base_reg(cur_vd), .sew(cur_sew), .elem_idx(elem_idx[i]),
                              .reg_idx(vd_reg[i]), .byte_off(vd_off[i]));
  end

  // All lanes of a cycle land in one register, so lane 0 names it
  vec_reg_file #(.LANES(LANES)) u_rf (
    .CLK, .nRST,
    .rd_reg_a(vs1_reg), .rd_off_a(vs1_off), .rd_reg_b(vs2_reg), .rd_off_b(vs2_off),
    .sew(cur_sew), .rd_data_a(data_a), .rd_data_b(data_b),
    .mask_idx(elem_idx), .mask_bit,
    .wr_en, .wr_reg(vd_reg[0]), .w_data, .byte_ena,
    .host_wen, .host_wreg, .host_wword, .host_wdata, .host_rreg, .host_rword, .host_rdata
  );

  vec_lane_alu #(.LANES(LANES)) u_alu (
    .op(cur_op), .sew(cur_sew), .a(data_a), .b(data_b), .result
  );

  vec_wb_align #(.LANES(LANES)) u_wb (
    .sew(cur_sew), .vm(cur_vm), .result, .byte_off(vd_off),
    .lane_valid, .mask_bit, .w_data, .byte_ena
  );

endmodule

// File: tests/vec_unit_assert.sv
// Concurrent assertions on the vector unit handshake
// done width and source, busy source, host write against the vector write
`timescale 1ns/1ps

module vec_unit_assert import vec_pkg::*; (
  input logic    CLK,
  input logic    nRST,
  input logic    start,
  input logic    busy,
  input logic    done,
  input logic    wr_en,
  input logic    host_wen,
  input regidx_t host_wreg,
  input regidx_t cur_vd
);

  // ========================================
  // Handshake rules
  // ========================================
  // Single-cycle done strobe
  done_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
    done |=> !done)
    else $error("done stayed high for more than one cycle");

  // done after a run, or right after start when vl is 0
  done_after_busy: assert property (@(posedge CLK) disable iff (!nRST)
    done |-> ($past(busy) || $past(start)))
    else $error("done arrived without a preceding run");

  // A run only begins from an accepted start
  busy_needs_start: assert property (@(posedge CLK) disable iff (!nRST)
    $rose(busy) |-> $past(start))
    else $error("busy rose with no start strobe");

  // Host port must keep off the register being written
  no_host_clash: assert property (@(posedge CLK) disable iff (!nRST)
    wr_en |-> !(host_wen && (host_wreg == cur_vd)))
    else $error("host write to vd during a vector write");

endmodule

bind vec_unit_top vec_unit_assert u_assert (
  .CLK, .nRST, .start, .busy, .done, .wr_en, .host_wen, .host_wreg, .cur_vd
);

// File: tests/vec_unit_tb.sv
// Vector unit testbench
// Reads operations and expected words from the vector file
// Preloads registers over the host port
// Runs each operation, times its done strobe and checks every register
`timescale 1ns/1ps
`include "vec_macros.svh"

module vec_unit_tb import vec_pkg::*; ();

  localparam int DONE_TIMEOUT = 300;
  localparam int VEC_DEPTH    = 64;

  logic        CLK = 1'b0;
  logic        nRST, start, vm, busy, done, host_wen;
  vop_t        op;
  sew_t        sew;
  offset_t     vl;
  regidx_t     vd, vs1, vs2, host_wreg, host_rreg;
  logic [1:0]  host_wword, host_rword;
  logic [31:0] host_wdata, host_rdata;

  // Expected contents of every register
  logic [127:0] shadow [`VEC_NUM_REGS];
  logic [127:0] vec_mem [VEC_DEPTH];
  int           error_count = 0;
  logic         hung = 1'b0;

  vec_unit_top DUT (.*);

  always #20 CLK = ~CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Writes one 32-bit word on the second edge
  task automatic host_write(input int r, input int w, input logic [31:0] d);
    @(posedge CLK);
    host_wen   <= 1'b1;
    host_wreg  <= regidx_t'(r);
    host_wword <= w[1:0];
    host_wdata <= d;
    @(posedge CLK);
    host_wen <= 1'b0;
  endtask

  task automatic host_read(input int r, input int w, output logic [31:0] d);
    @(posedge CLK);
    host_rreg  <= regidx_t'(r);
    host_rword <= w[1:0];
    @(negedge CLK);
    d = host_rdata;
  endtask

  task automatic load_reg(input int r, input logic [127:0] v);
    for (int w = 0; w < 4; w++) begin
      host_write(r, w, v[32*w +: 32]);
    end
    shadow[r] = v;
  endtask

  task automatic check_all(input string label);
    logic [31:0] word;
    for (int r = 0; r < `VEC_NUM_REGS; r++) begin
      for (int w = 0; w < 4; w++) begin
        host_read(r, w, word);
        check_value($sformatf("%s v%0d word %0d", label, r, w),
                    shadow[r][32*w +: 32], word);
      end
    end
  endtask

  // Issues the start strobe and a dropped second start and times done
  task automatic run_op(input logic [127:0] hdr, input int tnum);
    int cycles;
    int n_exp;
    n_exp = (int'(hdr[35:28]) + `VEC_LANES - 1) / `VEC_LANES;
    @(posedge CLK);
    start <= 1'b1;
    op    <= vop_t'(hdr[41:40]);
    sew   <= sew_t'(hdr[37:36]);
    vl    <= offset_t'(hdr[34:28]);
    vd    <= regidx_t'(hdr[24:20]);
    vs1   <= regidx_t'(hdr[16:12]);
    vs2   <= regidx_t'(hdr[8:4]);
    vm    <= hdr[0];
    @(posedge CLK);
    start <= 1'b0;
    cycles = 0;
    forever begin
      @(negedge CLK);
      cycles++;
      if (done || (cycles >= DONE_TIMEOUT)) break;
      @(posedge CLK);
      // Request aimed at v1 while busy is to be ignored
      start <= (cycles == 1) && (n_exp >= 2);
      vd    <= 5'd1;
    end
    if (!done) begin
      hung = 1'b1;
      error_count++;
      $display("Timeout: test %0d gave no done strobe in %0d cycles", tnum, DONE_TIMEOUT);
    end else begin
      check_value($sformatf("test %0d done latency", tnum), n_exp + 1, cycles);
    end
  endtask

  initial begin
    logic [127:0] hdr;
    logic [127:0] v0_word;
    logic [31:0]  rng;
    int           rec;
    int           tnum;
    int           rvd;
    nRST       = 1'b0;
    start      = 1'b0;
    op         = VOP_ADD;
    sew        = SEW8;
    vl         = '0;
    vd         = '0;
    vs1        = '0;
    vs2        = '0;
    vm         = 1'b1;
    host_wen   = 1'b0;
    host_wreg  = '0;
    host_wword = '0;
    host_wdata = '0;
    host_rreg  = '0;
    host_rword = '0;
    foreach (shadow[r]) shadow[r] = '0;
    foreach (vec_mem[i]) vec_mem[i] = '0;

    // ========================================
    // Reset and cleared state
    // ========================================
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_value("reset busy", 32'd0, {31'd0, busy});
    check_value("reset done", 32'd0, {31'd0, done});
    check_all("reset");

    // Random background in every register
    rng = 32'd60;
    for (int r = 0; r < `VEC_NUM_REGS; r++) begin
      for (int w = 0; w < 4; w++) begin
        rng = xorshift(rng);
        host_write(r, w, rng);
        shadow[r][32*w +: 32] = rng;
      end
    end

    // ========================================
    // Operation records
    // ========================================
    $readmemh("tests/vec_vectors.txt", vec_mem);
    rec = 4;
    while ((rec + 2 < VEC_DEPTH) && (vec_mem[rec] != '0) && !hung) begin
      hdr  = vec_mem[rec];
      tnum = int'(hdr[51:44]);
      rvd  = int'(hdr[27:20]);
      // v0 bits at and above vl set to expose any write past vl
      v0_word = vec_mem[2] | ({128{1'b1}} << int'(hdr[35:28]));
      load_reg(0, v0_word);
      // Both members of each group
      load_reg(int'(hdr[19:12]), vec_mem[0]);
      load_reg(int'(hdr[19:12]) + 1, vec_mem[0]);
      load_reg(int'(hdr[11:4]), vec_mem[1]);
      load_reg(int'(hdr[11:4]) + 1, vec_mem[1]);
      load_reg(rvd, vec_mem[3]);
      load_reg(rvd + 1, vec_mem[3]);
      run_op(hdr, tnum);
      if (!hung) begin
        shadow[rvd]     = vec_mem[rec + 1];
        shadow[rvd + 1] = vec_mem[rec + 2];
        check_all($sformatf("test %0d", tnum));
      end
      rec += 3;
    end
    if (rec == 4) begin
      error_count++;
      $display("No operation records were read from the vector file");
    end

    $display("Checks complete, %0d error(s)", error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+include
rtl/vec_pkg.sv
rtl/vec_elem_addr.sv
rtl/vec_reg_file.sv
rtl/vec_lane_alu.sv
rtl/vec_wb_align.sv
rtl/vec_seq_ctrl.sv
rtl/vec_unit_top.sv
tests/vec_unit_assert.sv
tests/vec_unit_tb.sv

// File: Makefile
# Verilator build and run for the vector unit testbench

VERILATOR ?= verilator
TOP       ?= vec_unit_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/vec_vectors.txt
// Globals: vs1 fill, vs2 fill / v0 mask, vd and vd+1 fill (128-bit words)
// Record: header TT O S VV DD AA BB M (test, op, sew, vl, vd, vs1, vs2, vm),
// then expected vd and expected vd+1
01010101010101010101010101010101 ffffffff000000001234567880ff7f00
00000000000000000000000000000535 ddddddddccccccccbbbbbbbbaaaaaaaa
// ADD, SUB, MV over one full register at each SEW
01001004080c1 00000000010101011335577981008001 ddddddddccccccccbbbbbbbbaaaaaaaa
0201081014181 01000100010101011335577982008001 ddddddddccccccccbbbbbbbbaaaaaaaa
0302041e02061 01010100010101011335577982008001 ddddddddccccccccbbbbbbbbaaaaaaaa
041010060a0e1 fefefefeffffffff113355777ffe7eff ddddddddccccccccbbbbbbbbaaaaaaaa
051108161a121 fefefefefefffeff113355777ffe7dff ddddddddccccccccbbbbbbbbaaaaaaaa
061204080c041 fefefefefefefeff113355777ffe7dff ddddddddccccccccbbbbbbbbaaaaaaaa
0720100a0c0e1 ffffffff000000001234567880ff7f00 ddddddddccccccccbbbbbbbbaaaaaaaa
08210814181c1 ffffffff000000001234567880ff7f00 ddddddddccccccccbbbbbbbbaaaaaaaa
0922040204061 ffffffff000000001234567880ff7f00 ddddddddccccccccbbbbbbbbaaaaaaaa
// Group into vd+1 with a partial tail, two full registers
0a02060c10141 01010100010101011335577982008001 ddddddddcccccccc1335577982008001
0b1110181c101 fefefefefefffeff113355777ffe7dff fefefefefefffeff113355777ffe7dff
// Masked SEW8 with vl = 11, then vl = 0
0c100b04080c0 ddddddddccffccffbbbb5577aafeaaff ddddddddccccccccbbbbbbbbaaaaaaaa
0d0000060a0e1 ddddddddccccccccbbbbbbbbaaaaaaaa ddddddddccccccccbbbbbbbbaaaaaaaa
